/* display_core.f */
hw/video_pkg.sv
hw/bridge_pkg.sv
hw/raster_timing.sv
hw/pixel_compositor.sv
hw/display_regs.sv
hw/i2s_clock_gen.sv
hw/display_core.sv
dv/tb_clock_gen.sv
dv/display_core_tb.sv
+incdir+dv

/* dv/display_core_tests.svh */
// directed tests for the display core
// included inside the testbench top, uses its signals and helpers

// outputs straight after reset release, before the first edge
task automatic reset_state();
    int                       e0;
    bridge_pkg::bridge_word_t rd;
    e0 = errors;
    @(posedge reset_n);
    check_value("video_vs", video_vs, 0);
    check_value("video_hs", video_hs, 0);
    check_value("video_de", video_de, 0);
    check_value("video_rgb", video_rgb, 0);
    check_value("audio_mclk", audio_mclk, 0);
    check_value("audio_lrck", audio_lrck, 0);
    check_value("audio_dac", audio_dac, 0);
    bridge_read(MODE_ADDR, rd);
    check_value("display_mode", rd, 0);
    finish_test("reset", e0);
endtask

// two frames of sync and de shape, starting on a vs pulse
task automatic raster_shape();
    int e0;
    int cyc;
    int last_vs;
    int last_hs;
    int de_run;
    int runs;
    int vs_count;
    e0 = errors;
    wait_frame_start();
    cyc      = 0;
    last_vs  = 0;
    last_hs  = -1;
    de_run   = 0;
    runs     = 0;
    vs_count = 0;
    repeat (2 * FRAME_CYCLES) begin
        next_cycle();
        cyc++;
        if (video_vs) begin
            check_value("video_vs period", cyc - last_vs, FRAME_CYCLES);
            check_value("video_de lines", runs, V_ACT);
            last_vs = cyc;
            runs    = 0;
            vs_count++;
        end
        // hs lands HS_OFF cycles behind vs
        if (cyc - last_vs == HS_OFF) begin
            check_that(video_hs, "hs missing three cycles after vs");
        end
        if (video_hs) begin
            if (last_hs >= 0) begin
                check_value("video_hs period", cyc - last_hs, H_TOT);
            end
            last_hs = cyc;
        end
        if (video_de) begin
            de_run++;
        end else begin
            if (de_run != 0) begin
                check_value("video_de run", de_run, H_ACT);
                runs++;
            end
            de_run = 0;
            check_value("video_rgb", video_rgb, 0);
        end
    end
    // one pulse ends each of the two frames
    check_value("video_vs count", vs_count, 2);
    finish_test("raster", e0);
endtask

// one frame per mode, pixel checked against last cycle's coordinates
task automatic pixel_select();
    int                e0;
    int                mode;
    int                de_count;
    video_pkg::coord_t px;
    video_pkg::coord_t py;
    video_pkg::rgb_t   exp;
    e0 = errors;
    for (mode = 0; mode < 2; mode++) begin
        bridge_write(MODE_ADDR, mode);
        wait_frame_start();
        de_count = 0;
        px = visible_x;
        py = visible_y;
        repeat (FRAME_CYCLES) begin
            next_cycle();
            if (video_de) begin
                // de pixels arrive in raster order from the window corner
                check_value("visible_x", px, de_count % H_ACT);
                check_value("visible_y", py, de_count / H_ACT);
                de_count++;
                if (mode == 0 && overlay_color(px, py) == video_pkg::OVERLAY_KEY) begin
                    exp = video_pkg::OVERLAY_KEY;
                end else begin
                    exp = fb_color(px, py);
                end
                check_value("video_rgb", video_rgb, exp);
            end
            px = visible_x;
            py = visible_y;
        end
        check_value("video_de count", de_count, H_ACT * V_ACT);
    end
    finish_test("compositing", e0);
endtask

task automatic register_access();
    int                       e0;
    int                       i;
    int                       pulses;
    bridge_pkg::bridge_word_t addr;
    bridge_pkg::bridge_word_t rd;
    bridge_pkg::bridge_word_t c0;
    bridge_pkg::bridge_word_t c1;
    e0 = errors;
    bridge_write(MODE_ADDR, 32'h1);
    bridge_read(MODE_ADDR, rd);
    check_value("display_mode", rd, 1);
    // only bit 0 is stored
    bridge_write(MODE_ADDR, 32'hFFFF_FFFE);
    bridge_read(MODE_ADDR, rd);
    check_value("display_mode", rd, 0);
    // half of the probes inside the register window
    for (i = 0; i < 8; i++) begin
        addr = random_word();
        if (i % 2 == 1) begin
            addr = {bridge_pkg::REG_BASE, addr[23:0]};
        end
        if (addr == MODE_ADDR || addr == FRAME_ADDR) begin
            addr = addr ^ 32'h8;
        end
        bridge_write(addr, random_word() | 32'h1);
        bridge_read(addr, rd);
        check_value("bridge_rd_data", rd, 0);
        bridge_read(MODE_ADDR, rd);
        check_value("display_mode", rd, 0);
    end
    bridge_read(FRAME_ADDR, c0);
    // the read strobe spans one edge, a vs on it counts too
    pulses = 0;
    if (video_vs) begin
        pulses++;
    end
    repeat (COUNT_CYCLES) begin
        next_cycle();
        if (video_vs) begin
            pulses++;
        end
    end
    bridge_read(FRAME_ADDR, c1);
    check_value("frame count step", (c1 - c0) & ((1 << bridge_pkg::FRAME_CNT_W) - 1), pulses);
    finish_test("registers", e0);
endtask

task automatic audio_clocks();
    int     e0;
    int     toggles;
    int     since_lrck;
    int     lrck_toggles;
    longint exp;
    logic   prev_mclk;
    logic   prev_lrck;
    e0           = errors;
    toggles      = 0;
    since_lrck   = 0;
    lrck_toggles = 0;
    prev_mclk    = audio_mclk;
    prev_lrck    = audio_lrck;
    repeat (AUDIO_CYCLES) begin
        next_cycle();
        if (audio_mclk !== prev_mclk) begin
            toggles++;
            since_lrck++;
        end
        // lrck moves on the same edge as an mclk toggle
        if (audio_lrck !== prev_lrck) begin
            if (lrck_toggles > 0) begin
                check_value("audio_mclk toggles per lrck", since_lrck, 256);
            end
            lrck_toggles++;
            since_lrck = 0;
        end
        check_value("audio_dac", audio_dac, 0);
        prev_mclk = audio_mclk;
        prev_lrck = audio_lrck;
    end
    exp = longint'(AUDIO_CYCLES) * MCLK_STEP / MCLK_WRAP;
    check_that(toggles >= exp - 1 && toggles <= exp + 1,
               $sformatf("mclk toggled %0d times, expected about %0d", toggles, exp));
    check_that(lrck_toggles >= 2, "lrck toggled fewer than two times");
    finish_test("audio", e0);
endtask

/* dv/display_core_tb.sv */
// testbench top for the display core
// small raster so whole frames pass quickly, pixel sources modelled
// as functions of the coordinates the DUT drives out

`timescale 1ns/1ps

module display_core_tb;

    localparam int CLK_PERIOD_NS = 4;

    // 40x20 frame, 24x12 visible
    localparam video_pkg::coord_t H_TOT  = 10'd40;
    localparam video_pkg::coord_t H_ACT  = 10'd24;
    localparam video_pkg::coord_t H_BP   = 10'd8;
    localparam video_pkg::coord_t V_TOT  = 10'd20;
    localparam video_pkg::coord_t V_ACT  = 10'd12;
    localparam video_pkg::coord_t V_BP   = 10'd4;
    localparam video_pkg::coord_t HS_OFF = 10'd3;
    localparam int MCLK_STEP = 245760;
    localparam int MCLK_WRAP = 742500;

    localparam int FRAME_CYCLES = 40 * 20;
    localparam int COUNT_CYCLES = 2000;
    localparam int AUDIO_CYCLES = 20000;
    // four checked frames, four frames of vs waits at most, counting and audio
    localparam int WATCHDOG_CYCLES = 8 * FRAME_CYCLES + COUNT_CYCLES + AUDIO_CYCLES + 1000;

    localparam bridge_pkg::bridge_word_t MODE_ADDR =
        {bridge_pkg::REG_BASE, bridge_pkg::REG_MODE_OFFSET};
    localparam bridge_pkg::bridge_word_t FRAME_ADDR =
        {bridge_pkg::REG_BASE, bridge_pkg::REG_FRAME_OFFSET};

    localparam logic [23:0] FB_SEED = 24'h5A3C96;

    logic                     clk_74a;
    logic                     reset_n;
    bridge_pkg::bridge_word_t bridge_addr;
    logic                     bridge_rd;
    bridge_pkg::bridge_word_t bridge_rd_data;
    logic                     bridge_wr;
    bridge_pkg::bridge_word_t bridge_wr_data;
    video_pkg::rgb_t          overlay_rgb;
    video_pkg::rgb_t          fb_rgb;
    video_pkg::coord_t        visible_x;
    video_pkg::coord_t        visible_y;
    video_pkg::rgb_t          video_rgb;
    logic                     video_de;
    logic                     video_hs;
    logic                     video_vs;
    logic                     audio_mclk;
    logic                     audio_lrck;
    logic                     audio_dac;

    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    logic [31:0] rng_state = 32'd12111;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) u_clock_gen (
        .clk_74a (clk_74a),
        .reset_n (reset_n)
    );

    display_core #(
        .H_TOTAL   (H_TOT),
        .H_ACTIVE  (H_ACT),
        .H_BPORCH  (H_BP),
        .V_TOTAL   (V_TOT),
        .V_ACTIVE  (V_ACT),
        .V_BPORCH  (V_BP),
        .HS_OFFSET (HS_OFF),
        .MCLK_STEP (MCLK_STEP),
        .MCLK_WRAP (MCLK_WRAP)
    ) u_dut (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .overlay_rgb    (overlay_rgb),
        .fb_rgb         (fb_rgb),
        .visible_x      (visible_x),
        .visible_y      (visible_y),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .audio_mclk     (audio_mclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    ////////////////////////////////////////////////////////////
    // pixel source models
    ////////////////////////////////////////////////////////////

    // xorshift32, 13/17/5
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic video_pkg::rgb_t fb_color(input video_pkg::coord_t x,
                                                 input video_pkg::coord_t y);
        logic [7:0] sum;
        sum = x[7:0] + y[7:0];
        return {x[7:0] ^ FB_SEED[23:16], y[7:0] ^ FB_SEED[15:8], sum ^ FB_SEED[7:0]};
    endfunction

    // white on every column with bit 2 set, otherwise a hashed colour
    // with the channel lsbs cleared so it is never white
    function automatic video_pkg::rgb_t overlay_color(input video_pkg::coord_t x,
                                                      input video_pkg::coord_t y);
        logic [31:0] h;
        if (x[2]) begin
            return video_pkg::OVERLAY_KEY;
        end
        h = xorshift(32'd12111 ^ {12'd0, x, y});
        return h[23:0] & 24'hFEFEFE;
    endfunction

    assign fb_rgb      = fb_color(visible_x, visible_y);
    assign overlay_rgb = overlay_color(visible_x, visible_y);

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // every step ends 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_74a);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_that(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // single-cycle write strobe, mode changes on that edge
    task automatic bridge_write(input bridge_pkg::bridge_word_t addr,
                                input bridge_pkg::bridge_word_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        next_cycle();
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
    endtask

    // single-cycle read strobe
    // data is combinational, sampled 1 ns after the address
    task automatic bridge_read(input bridge_pkg::bridge_word_t addr,
                               output bridge_pkg::bridge_word_t data);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        #1;
        data        = bridge_rd_data;
        next_cycle();
        bridge_rd   = 1'b0;
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        while (!video_vs && n < 2 * FRAME_CYCLES) begin
            next_cycle();
            n++;
        end
        check_that(video_vs, "no vs pulse within two frames");
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        $display("test %-12s done, %0d errors", name, errors - errors_before);
    endtask

    `include "display_core_tests.svh"

    ////////////////////////////////////////////////////////////
    // sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        reset_state();
        raster_shape();
        pixel_select();
        register_access();
        audio_clocks();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* dv/tb_clock_gen.sv */
// clock and reset source for the display core testbench
// free-running clk_74a, reset_n held low for a few cycles and
// released just after a rising edge

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_74a,
    output logic reset_n
);

    initial begin
        clk_74a = 1'b0;
        forever #(PERIOD_NS / 2) clk_74a = ~clk_74a;
    end

    // release lands 1 ns after an edge, same as the other stimulus
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_74a);
        #1;
        reset_n = 1'b1;
    end

endmodule

/* hw/bridge_pkg.sv */
// host bridge word type and the register window of the display core
// addresses are full 32-bit bridge byte addresses, the window is
// selected by the upper address byte

package bridge_pkg;

    // bridge address and data are both one 32-bit word
    typedef logic [31:0] bridge_word_t;

    // upper address byte of the register window
    localparam logic [7:0] REG_BASE = 8'hF8;

    // word offsets inside the window, low 24 address bits
    localparam logic [23:0] REG_MODE_OFFSET  = 24'h000000;
    localparam logic [23:0] REG_FRAME_OFFSET = 24'h000004;

    // frame counter width, wraps silently
    localparam int FRAME_CNT_W = 16;

endpackage

/* hw/display_core.sv */
// display and audio core top level
// raster timing feeds the compositor, the register block supplies
// the display mode, the i2s clocks run free; pixel sources sit
// outside and are looked up from visible_x and visible_y

`timescale 1ns/1ps

module display_core #(
    parameter video_pkg::coord_t H_TOTAL   = video_pkg::DEF_H_TOTAL,
    parameter video_pkg::coord_t H_ACTIVE  = video_pkg::DEF_H_ACTIVE,
    parameter video_pkg::coord_t H_BPORCH  = video_pkg::DEF_H_BPORCH,
    parameter video_pkg::coord_t V_TOTAL   = video_pkg::DEF_V_TOTAL,
    parameter video_pkg::coord_t V_ACTIVE  = video_pkg::DEF_V_ACTIVE,
    parameter video_pkg::coord_t V_BPORCH  = video_pkg::DEF_V_BPORCH,
    parameter video_pkg::coord_t HS_OFFSET = video_pkg::DEF_HS_OFFSET,
    parameter int                MCLK_STEP = 245760,
    parameter int                MCLK_WRAP = 742500
) (
    input  logic                     clk_74a,
    input  logic                     reset_n,

    // bridge, synchronous to clk_74a
    // reads decode from the address alone, the read strobe is not needed
    input  bridge_pkg::bridge_word_t bridge_addr,
    input  logic                     bridge_rd,
    output bridge_pkg::bridge_word_t bridge_rd_data,
    input  logic                     bridge_wr,
    input  bridge_pkg::bridge_word_t bridge_wr_data,

    // pixel sources, looked up from the coordinates below
    input  video_pkg::rgb_t          overlay_rgb,
    input  video_pkg::rgb_t          fb_rgb,
    output video_pkg::coord_t        visible_x,
    output video_pkg::coord_t        visible_y,

    // video out
    output video_pkg::rgb_t          video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs,

    // audio out
    output logic                     audio_mclk,
    output logic                     audio_lrck,
    output logic                     audio_dac
);

    logic frame_start;
    logic hs_mark;
    logic active;
    logic display_mode;

    ////////////////////////////////////////////////////////////
    // video path
    ////////////////////////////////////////////////////////////

    raster_timing #(
        .H_TOTAL   (H_TOTAL),
        .H_ACTIVE  (H_ACTIVE),
        .H_BPORCH  (H_BPORCH),
        .V_TOTAL   (V_TOTAL),
        .V_ACTIVE  (V_ACTIVE),
        .V_BPORCH  (V_BPORCH),
        .HS_OFFSET (HS_OFFSET)
    ) u_raster_timing (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .hs_mark     (hs_mark),
        .active      (active),
        .visible_x   (visible_x),
        .visible_y   (visible_y)
    );

    pixel_compositor u_pixel_compositor (
        .clk_74a      (clk_74a),
        .reset_n      (reset_n),
        .frame_start  (frame_start),
        .hs_mark      (hs_mark),
        .active       (active),
        .display_mode (display_mode),
        .overlay_rgb  (overlay_rgb),
        .fb_rgb       (fb_rgb),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs)
    );

    // mode register and frame count behind the bridge
    display_regs u_display_regs (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .frame_start    (frame_start),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .display_mode   (display_mode),
        .bridge_rd_data (bridge_rd_data)
    );

    ////////////////////////////////////////////////////////////
    // audio clocks
    ////////////////////////////////////////////////////////////

    i2s_clock_gen #(
        .MCLK_STEP (MCLK_STEP),
        .MCLK_WRAP (MCLK_WRAP)
    ) u_i2s_clock_gen (
        .clk_74a    (clk_74a),
        .reset_n    (reset_n),
        .audio_mclk (audio_mclk),
        .audio_lrck (audio_lrck),
        .audio_dac  (audio_dac)
    );

endmodule

/* hw/display_regs.sv */
// bridge register block of the display core
// one writable mode bit and a read-only frame counter in the
// 0xF8 window; writes land one cycle after the strobe, reads are
// decoded combinationally from the address

`timescale 1ns/1ps

module display_regs (
    input  logic                    clk_74a,
    input  logic                    reset_n,
    input  logic                    frame_start,
    input  bridge_pkg::bridge_word_t bridge_addr,
    input  logic                    bridge_wr,
    input  bridge_pkg::bridge_word_t bridge_wr_data,
    output logic                    display_mode,
    output bridge_pkg::bridge_word_t bridge_rd_data
);

    // full byte addresses of the two registers
    localparam bridge_pkg::bridge_word_t MODE_ADDR =
        {bridge_pkg::REG_BASE, bridge_pkg::REG_MODE_OFFSET};
    localparam bridge_pkg::bridge_word_t FRAME_ADDR =
        {bridge_pkg::REG_BASE, bridge_pkg::REG_FRAME_OFFSET};

    logic [bridge_pkg::FRAME_CNT_W-1:0] frame_cnt;
    logic                               mode_wr;

    ////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////

    // only the mode register is writable, anything else is dropped
    assign mode_wr = bridge_wr && (bridge_addr == MODE_ADDR);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            display_mode <= 1'b0;
        end else if (mode_wr) begin
            display_mode <= bridge_wr_data[0];
        end
    end

    // frame counter, one step per frame origin
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            frame_cnt <= '0;
        end else if (frame_start) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (bridge_addr)
            MODE_ADDR:  bridge_rd_data = {31'b0, display_mode};
            // count is zero-extended into the word
            FRAME_ADDR: bridge_rd_data = bridge_pkg::bridge_word_t'(frame_cnt);
            default:    bridge_rd_data = '0;
        endcase
    end

endmodule

/* hw/i2s_clock_gen.sv */
// silent i2s clock generator
// mclk from a fractional accumulator on clk_74a, sclk at mclk/4 and
// lrck every 32 sclk periods; all three run as registered outputs
// stepped by enables, the dac line stays low

`timescale 1ns/1ps

module i2s_clock_gen #(
    parameter int MCLK_STEP = 245760,
    parameter int MCLK_WRAP = 742500
) (
    input  logic clk_74a,
    input  logic reset_n,
    output logic audio_mclk,
    output logic audio_lrck,
    output logic audio_dac
);

    // wide enough for the largest value, wrap - 1 + step
    localparam int ACC_W = $clog2(MCLK_WRAP + MCLK_STEP + 1);
    localparam logic [ACC_W-1:0] STEP = ACC_W'(MCLK_STEP);
    localparam logic [ACC_W-1:0] WRAP = ACC_W'(MCLK_WRAP);

    logic [ACC_W-1:0] accum;
    logic             mclk_toggle;
    logic             mclk_rise;
    logic [1:0]       mclk_div;
    logic [1:0]       mclk_div_next;
    logic             sclk;
    logic             sclk_fall;
    logic [4:0]       lrck_cnt;

    ////////////////////////////////////////////////////////////
    // mclk, average rate clk_74a * step / (2 * wrap)
    ////////////////////////////////////////////////////////////

    assign mclk_toggle = (accum >= WRAP);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            accum      <= '0;
            audio_mclk <= 1'b0;
        end else if (mclk_toggle) begin
            accum      <= accum - WRAP + STEP;
            audio_mclk <= ~audio_mclk;
        end else begin
            accum <= accum + STEP;
        end
    end

    ////////////////////////////////////////////////////////////
    // sclk and lrck
    ////////////////////////////////////////////////////////////

    // enable for the cycle where mclk goes high
    assign mclk_rise     = mclk_toggle && !audio_mclk;
    assign mclk_div_next = mclk_div + 2'd1;
    assign sclk          = mclk_div[1];
    // sclk drops when the divider rolls over from 3
    assign sclk_fall     = mclk_rise && sclk && !mclk_div_next[1];

    // no samples to send, all bit slots are silent
    assign audio_dac = 1'b0;

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div   <= '0;
            lrck_cnt   <= '0;
            audio_lrck <= 1'b0;
        end else begin
            if (mclk_rise) begin
                mclk_div <= mclk_div_next;
            end
            if (sclk_fall) begin
                // 32 bit slots per channel
                lrck_cnt <= lrck_cnt + 5'd1;
                if (lrck_cnt == 5'd31) begin
                    audio_lrck <= ~audio_lrck;
                end
            end
        end
    end

endmodule

/* hw/pixel_compositor.sv */
// pixel compositor
// picks between the text overlay and the framebuffer pixel and
// registers it together with hs, vs and de, one cycle after the
// raster position that produced the strobes

`timescale 1ns/1ps

module pixel_compositor (
    input  logic            clk_74a,
    input  logic            reset_n,
    input  logic            frame_start,
    input  logic            hs_mark,
    input  logic            active,
    input  logic            display_mode,
    input  video_pkg::rgb_t overlay_rgb,
    input  video_pkg::rgb_t fb_rgb,
    output video_pkg::rgb_t video_rgb,
    output logic            video_de,
    output logic            video_hs,
    output logic            video_vs
);

    video_pkg::rgb_t pix_next;

    // mode 1 shows the framebuffer only
    // mode 0 lets white overlay text sit on top of the framebuffer
    always_comb begin
        if (!active) begin
            // blanking is black
            pix_next = '0;
        end else if (display_mode) begin
            pix_next = fb_rgb;
        end else if (overlay_rgb == video_pkg::OVERLAY_KEY) begin
            pix_next = overlay_rgb;
        end else begin
            pix_next = fb_rgb;
        end
    end

    // output stage, everything lands on the same edge
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= pix_next;
            video_de  <= active;
            video_hs  <= hs_mark;
            video_vs  <= frame_start;
        end
    end

endmodule

/* hw/raster_timing.sv */
// raster timing generator
// free-running x/y counters on clk_74a, one pixel per cycle
// all outputs are decoded straight from the counter registers, so
// the caller registers them once to line up sync, de and pixel

`timescale 1ns/1ps

module raster_timing #(
    parameter video_pkg::coord_t H_TOTAL   = video_pkg::DEF_H_TOTAL,
    parameter video_pkg::coord_t H_ACTIVE  = video_pkg::DEF_H_ACTIVE,
    parameter video_pkg::coord_t H_BPORCH  = video_pkg::DEF_H_BPORCH,
    parameter video_pkg::coord_t V_TOTAL   = video_pkg::DEF_V_TOTAL,
    parameter video_pkg::coord_t V_ACTIVE  = video_pkg::DEF_V_ACTIVE,
    parameter video_pkg::coord_t V_BPORCH  = video_pkg::DEF_V_BPORCH,
    parameter video_pkg::coord_t HS_OFFSET = video_pkg::DEF_HS_OFFSET
) (
    input  logic              clk_74a,
    input  logic              reset_n,
    output logic              frame_start,
    output logic              hs_mark,
    output logic              active,
    output video_pkg::coord_t visible_x,
    output video_pkg::coord_t visible_y
);

    // end of the active window, exclusive
    localparam video_pkg::coord_t H_END = H_BPORCH + H_ACTIVE;
    localparam video_pkg::coord_t V_END = V_BPORCH + V_ACTIVE;

    video_pkg::coord_t x_count;
    video_pkg::coord_t y_count;
    logic              x_last;
    logic              y_last;
    logic              h_active;
    logic              v_active;

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////

    assign x_last = (x_count == H_TOTAL - 10'd1);
    assign y_last = (y_count == V_TOTAL - 10'd1);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            // x wraps every line, y steps once per wrap of x
            if (x_last) begin
                x_count <= '0;
                if (y_last) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + 10'd1;
                end
            end else begin
                x_count <= x_count + 10'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // decodes
    ////////////////////////////////////////////////////////////

    // frame origin, one cycle per frame
    assign frame_start = (x_count == '0) && (y_count == '0);

    // sync column, one cycle per line
    assign hs_mark = (x_count == HS_OFFSET);

    assign h_active = (x_count >= H_BPORCH) && (x_count < H_END);
    assign v_active = (y_count >= V_BPORCH) && (y_count < V_END);
    assign active   = h_active && v_active;

    // coordinates relative to the back porch
    // only meaningful inside the window, they wrap outside it
    assign visible_x = x_count - H_BPORCH;
    assign visible_y = y_count - V_BPORCH;

endmodule

/* hw/video_pkg.sv */
// video types and default raster timing for the display core
// pixel and coordinate widths are shared by the timing generator,
// the compositor, the top level and the testbench

package video_pkg;

    // one 24-bit pixel, r in the top byte
    typedef logic [23:0] rgb_t;

    // raster counter or visible coordinate
    typedef logic [9:0] coord_t;

    // overlay pixels of exactly this colour win over the framebuffer
    localparam rgb_t OVERLAY_KEY = 24'hFFFFFF;

    //////////////////////////////////////////////////////////
    // default raster, 320x240 visible in a 400x512 frame
    //////////////////////////////////////////////////////////

    localparam coord_t DEF_H_TOTAL  = 10'd400;
    localparam coord_t DEF_H_ACTIVE = 10'd320;
    localparam coord_t DEF_H_BPORCH = 10'd40;
    localparam coord_t DEF_V_TOTAL  = 10'd512;
    localparam coord_t DEF_V_ACTIVE = 10'd240;
    localparam coord_t DEF_V_BPORCH = 10'd16;

    // hs sits a few columns in, so it never lands on the vs cycle
    localparam coord_t DEF_HS_OFFSET = 10'd3;

endpackage
